//--- src/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h8000_0000

// cacheable window, base inclusive, limit exclusive
`define CACHED_BASE 32'h8000_0000
`define CACHED_LIMIT 32'h8000_4000

// cache geometry
`define LINE_WORDS 4
`define CACHE_LINES 16

`endif

//--- src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	// burst kind as on the AXI read channel
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR = 2'b01
	} rd_burst_e;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] len; // beats minus one
		rd_burst_e burst;
	} rd_req_s;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp; // not checked by the fetch path
		logic last;
	} rd_beat_s;

endpackage

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	typedef logic [31-$clog2(`CACHE_LINES)-$clog2(`LINE_WORDS)-2:0] line_tag_t;
	typedef logic [$clog2(`CACHE_LINES)-1:0] line_index_t;
	typedef logic [$clog2(`LINE_WORDS)-1:0] line_word_t;

	typedef struct packed {
		line_tag_t tag;
		line_index_t index;
		line_word_t word;
		logic [1:0] byte_off;
	} line_fields_s;

	// same address word, raw for arithmetic or split for the cache
	typedef union packed {
		logic [31:0] raw;
		line_fields_s line;
	} fetch_addr_u;

	typedef struct packed {
		logic [31:0] target;
	} redirect_s;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] insn;
	} fetch_out_s;

endpackage

`default_nettype wire

//--- src/pc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module pc_sequencer import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	input logic redirect,
	input redirect_s redirect_info,
	input logic consumed,
	input logic fetch_done,
	output logic fetch_req,
	output fetch_addr_u fetch_addr,
	output logic flush
);

	fetch_addr_u pc;
	logic in_flight;
	logic pending; // redirect seen while a fetch was out
	logic busy;

	// a fetch counts as out from its request up to its done strobe
	assign busy = (in_flight | fetch_req) & ~fetch_done;
	assign flush = redirect | pending;
	assign fetch_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc.raw <= `FETCH_RESET_PC;
			fetch_req <= 1'b1; // boot fetch as soon as reset drops
			in_flight <= 1'b0;
			pending <= 1'b0;
		end else begin
			fetch_req <= 1'b0;
			in_flight <= busy;
			pending <= pending & ~fetch_done;
			if (redirect) begin
				pc.raw <= redirect_info.target;
				if (busy) begin
					pending <= 1'b1; // wait for the stale result to drain
				end else begin
					fetch_req <= 1'b1;
				end
			end else if (pending & fetch_done) begin
				fetch_req <= 1'b1;
			end else if (consumed) begin
				pc.raw <= pc.raw + 32'd4;
				fetch_req <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/icache_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module icache_array import fetch_pkg::*, mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input fetch_addr_u fetch_addr,
	output logic miss_req,
	output fetch_addr_u miss_addr,
	output logic miss_cached,
	input logic beat_valid,
	input rd_beat_s beat,
	output logic fetch_done,
	output fetch_out_s result
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL
	} state_e;

	state_e state;
	fetch_addr_u req_addr;
	logic cached;
	line_tag_t tag_q;
	logic valid_q;
	logic [31:0] data_q;
	line_word_t fill_word;
	logic [`CACHE_LINES-1:0] line_valid;
	logic in_window;
	logic hit;

	line_tag_t tag_mem [`CACHE_LINES];
	logic [31:0] data_mem [`CACHE_LINES*`LINE_WORDS];

	assign in_window = (fetch_addr.raw >= `CACHED_BASE) && (fetch_addr.raw < `CACHED_LIMIT);
	assign hit = cached & valid_q & (tag_q == req_addr.line.tag);
	assign miss_addr = req_addr;
	assign miss_cached = cached;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			miss_req <= 1'b0;
			fetch_done <= 1'b0;
			fill_word <= '0;
			line_valid <= '0;
		end else begin
			miss_req <= 1'b0;
			fetch_done <= 1'b0;
			case (state)
				IDLE: begin
					if (fetch_req)
						state <= LOOKUP; // arrays read this cycle
				end
				LOOKUP: begin
					if (hit) begin
						fetch_done <= 1'b1;
						state <= IDLE;
					end else begin
						miss_req <= 1'b1; // uncached fetches land here too
						fill_word <= '0;
						state <= REFILL;
					end
				end
				REFILL: begin
					if (beat_valid) begin
						fill_word <= fill_word + 1'b1;
						if (beat.last) begin
							fetch_done <= 1'b1;
							state <= IDLE;
							if (cached)
								line_valid[req_addr.line.index] <= 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_req) begin
			req_addr <= fetch_addr;
			cached <= in_window;
			tag_q <= tag_mem[fetch_addr.line.index];
			valid_q <= line_valid[fetch_addr.line.index];
			data_q <= data_mem[{fetch_addr.line.index, fetch_addr.line.word}];
		end
		if (state == LOOKUP)
			result <= '{pc: req_addr.raw, insn: data_q};
		if (state == REFILL && beat_valid) begin
			if (cached)
				data_mem[{req_addr.line.index, fill_word}] <= beat.data;
			// grab the wanted word as the line streams past
			if (!cached || fill_word == req_addr.line.word)
				result.insn <= beat.data;
			if (cached && beat.last)
				tag_mem[req_addr.line.index] <= req_addr.line.tag;
		end
	end

endmodule

`default_nettype wire

//--- src/fetch_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_bus_master import fetch_pkg::*, mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic miss_req,
	input fetch_addr_u miss_addr,
	input logic miss_cached,
	output logic ar_valid,
	output rd_req_s ar,
	input logic ar_ready,
	input logic r_valid,
	input rd_beat_s r,
	output logic beat_valid,
	output rd_beat_s beat
);

	fetch_addr_u line_addr;
	logic rd_busy; // beats still owed

	// line aligned start of a refill burst
	always_comb begin
		line_addr = miss_addr;
		line_addr.line.word = '0;
		line_addr.line.byte_off = '0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid <= 1'b0;
			rd_busy <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= r_valid & rd_busy;
			if (miss_req) begin
				ar_valid <= 1'b1;
				rd_busy <= 1'b1;
			end else begin
				if (ar_valid & ar_ready)
					ar_valid <= 1'b0;
				if (r_valid & rd_busy & r.last)
					rd_busy <= 1'b0;
			end
		end
	end

	// request only changes on a new miss, so it holds until accepted
	always_ff @(posedge clock) begin
		if (miss_req) begin
			if (miss_cached) begin
				ar <= '{addr: line_addr.raw, len: 4'(`LINE_WORDS - 1), burst: BURST_INCR};
			end else begin
				ar <= '{addr: miss_addr.raw, len: 4'd0, burst: BURST_FIXED};
			end
		end
		if (r_valid)
			beat <= r;
	end

endmodule

`default_nettype wire

//--- src/decode_handoff.sv
`timescale 1ns/10ps
`default_nettype none

module decode_handoff import fetch_pkg::*; (
	input logic clock,
	input logic reset,
	input logic fetch_done,
	input fetch_out_s result,
	input logic flush,
	output logic out_valid,
	output fetch_out_s out,
	input logic out_ready,
	output logic consumed
);

	assign consumed = out_valid & out_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0; // drop held or late wrong-path word
		end else if (fetch_done) begin
			out_valid <= 1'b1;
		end else if (consumed) begin
			out_valid <= 1'b0;
		end
	end

	// loads only when empty, so held output stays put under back-pressure
	always_ff @(posedge clock) begin
		if (fetch_done)
			out <= result;
	end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top import fetch_pkg::*, mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic redirect,
	input redirect_s redirect_info,
	output logic out_valid,
	output fetch_out_s out,
	input logic out_ready,
	output logic ar_valid,
	output rd_req_s ar,
	input logic ar_ready,
	input logic r_valid,
	input rd_beat_s r
);

	logic fetch_req;
	fetch_addr_u fetch_addr;
	logic flush;
	logic consumed;
	logic miss_req;
	fetch_addr_u miss_addr;
	logic miss_cached;
	logic beat_valid;
	rd_beat_s beat;
	logic fetch_done;
	fetch_out_s result;

	pc_sequencer pc_sequencer_i (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_info(redirect_info),
		.consumed(consumed),
		.fetch_done(fetch_done),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.flush(flush)
	);

	icache_array icache_array_i (
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.miss_req(miss_req),
		.miss_addr(miss_addr),
		.miss_cached(miss_cached),
		.beat_valid(beat_valid),
		.beat(beat),
		.fetch_done(fetch_done),
		.result(result)
	);

	fetch_bus_master fetch_bus_master_i (
		.clock(clock),
		.reset(reset),
		.miss_req(miss_req),
		.miss_addr(miss_addr),
		.miss_cached(miss_cached),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r(r),
		.beat_valid(beat_valid),
		.beat(beat)
	);

	decode_handoff decode_handoff_i (
		.clock(clock),
		.reset(reset),
		.fetch_done(fetch_done),
		.result(result),
		.flush(flush),
		.out_valid(out_valid),
		.out(out),
		.out_ready(out_ready),
		.consumed(consumed)
	);

endmodule

`default_nettype wire

//--- sim/fetch_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_model import mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	input rd_req_s ar,
	output logic ar_ready,
	output logic r_valid,
	output rd_beat_s r,
	input logic [1:0] latency,
	output int req_count
);

	logic [31:0] img_addr [64];
	logic [31:0] img_data [64];
	int img_words = 0;
	logic busy;
	logic incr; // step address per beat
	logic [31:0] addr;
	logic [3:0] left;
	logic [1:0] delay;

	task automatic load_word(input logic [31:0] a, input logic [31:0] d);
		img_addr[img_words] = a;
		img_data[img_words] = d;
		img_words++;
	endtask

	// words not in the image get a pattern from the full address
	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [31:0] d;
		d = {a[15:0], a[31:16]} ^ 32'h6b8b_4567;
		for (int i = 0; i < img_words; i++) begin
			if (img_addr[i] == a)
				d = img_data[i];
		end
		return d;
	endfunction

	assign ar_ready = ~busy; // one burst at a time

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			r_valid <= 1'b0;
			req_count <= 0;
		end else begin
			r_valid <= 1'b0;
			if (!busy) begin
				if (ar_valid) begin
					busy <= 1'b1;
					addr <= ar.addr;
					left <= ar.len;
					incr <= (ar.burst == BURST_INCR);
					delay <= latency;
					req_count <= req_count + 1;
				end
			end else if (delay != 2'd0) begin
				delay <= delay - 2'd1;
			end else begin
				r_valid <= 1'b1;
				r <= '{data: read_word(addr), resp: 2'b00, last: (left == 4'd0)};
				if (incr)
					addr <= addr + 32'd4;
				if (left == 4'd0)
					busy <= 1'b0;
				else
					left <= left - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/fetch_chk.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_chk import fetch_pkg::*, mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic out_valid,
	input fetch_out_s out,
	input logic out_ready,
	input logic ar_valid,
	input rd_req_s ar,
	input logic ar_ready
);

	int failures = 0;

	// held word stays until taken or dropped by a redirect
	held_out: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect |=> out_valid && $stable(out))
		else begin
			$error("decode output changed while stalled");
			failures++;
		end

	held_req: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			$error("read request changed before it was accepted");
			failures++;
		end

	quiet_after_redirect: assert property (@(posedge clock) disable iff (reset)
		redirect |=> !$rose(out_valid))
		else begin
			$error("decode output became valid right after a redirect");
			failures++;
		end

endmodule

bind fetch_top fetch_chk chk_i (
	.clock(clock),
	.reset(reset),
	.redirect(redirect),
	.out_valid(out_valid),
	.out(out),
	.out_ready(out_ready),
	.ar_valid(ar_valid),
	.ar(ar),
	.ar_ready(ar_ready)
);

`default_nettype wire

//--- sim/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*, mem_bus_pkg::*; ();

	logic clock;
	logic reset;
	logic redirect;
	redirect_s redirect_info;
	logic out_valid;
	fetch_out_s out;
	logic out_ready;
	logic ar_valid;
	rd_req_s ar;
	logic ar_ready;
	logic r_valid;
	rd_beat_s r;
	logic [1:0] latency;
	int req_count;

	logic [31:0] golden [0:255];
	logic [15:0] lfsr;
	int test_errors [4];
	int failed_tests = 0;
	int accepted = 0;
	int expected_count = 0;
	int final_reqs = 0;
	int cycles = 0;
	int cycle_limit = 0;

	fetch_top dut_i (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_info(redirect_info),
		.out_valid(out_valid),
		.out(out),
		.out_ready(out_ready),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r(r)
	);

	fetch_mem_model mem_i (
		.clock(clock),
		.reset(reset),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r(r),
		.latency(latency),
		.req_count(req_count)
	);

	function automatic string test_name(input int test);
		case (test)
			0: return "reset";
			1: return "stream";
			2: return "bus";
			default: return "handshake";
		endcase
	endfunction

	task automatic compare(input int test, input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s, %s: expected %h, actual %h", test_name(test), name,
				expected, actual);
			test_errors[test]++;
		end
	endtask

	task automatic report_test(input int test);
		if (test_errors[test] == 0) begin
			$display("test %s: ok", test_name(test));
		end else begin
			$display("test %s: %0d errors", test_name(test), test_errors[test]);
			failed_tests++;
		end
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic draw_bits(output logic [1:0] bits);
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_step(lfsr);
			bits[i] = lfsr[0];
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// transfers and bus requests seen at the edge that takes them
	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (out_valid && out_ready) begin
				if (accepted >= expected_count) begin
					$display("an output was accepted after the expected stream had ended");
					test_errors[1]++;
				end else begin
					if (accepted == 0)
						compare(1, "first pc", `FETCH_RESET_PC, out.pc);
					compare(1, $sformatf("stream[%0d] pc", accepted),
						golden['h80 + 2 * accepted], out.pc);
					compare(1, $sformatf("stream[%0d] insn", accepted),
						golden['h81 + 2 * accepted], out.insn);
				end
				accepted++;
				if (accepted == expected_count)
					final_reqs = req_count;
			end
			if (ar_valid && ar_ready) begin
				if (ar.addr >= `CACHED_BASE && ar.addr < `CACHED_LIMIT) begin
					compare(2, "refill burst kind", BURST_INCR, ar.burst);
					compare(2, "refill beat count", `LINE_WORDS, ar.len + 1);
					compare(2, "refill line alignment", 0, ar.addr[3:0]);
				end else begin
					compare(2, "uncached burst kind", BURST_FIXED, ar.burst);
					compare(2, "uncached beat count", 1, ar.len + 1);
				end
			end
		end
	end

	initial begin
		wait (cycle_limit > 0 && cycles > cycle_limit);
		$display("timeout: the fetch stream did not complete within %0d cycles", cycle_limit);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [1:0] bits;
		int mem_words;
		int redirects;
		int next_redirect;
		int base;
		int total;

		reset = 1'b1;
		redirect = 1'b0;
		redirect_info = '0;
		out_ready = 1'b0;
		latency = 2'd0;
		lfsr = 16'd7;
		for (int i = 0; i < 4; i++)
			test_errors[i] = 0;
		$readmemh("sim/fetch_golden.hex", golden);
		mem_words = golden[0];
		redirects = golden[1];
		expected_count = golden[2];
		cycle_limit = 40 * expected_count + 200;
		for (int i = 0; i < mem_words; i++)
			mem_i.load_word(golden['h10 + 2 * i], golden['h11 + 2 * i]);

		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		compare(0, "out_valid after reset", 0, out_valid);
		compare(0, "ar_valid after reset", 0, ar_valid);
		report_test(0);

		next_redirect = 0;
		while (accepted < expected_count) begin
			@(negedge clock);
			draw_bits(bits);
			out_ready = (bits != 2'b00);
			draw_bits(bits);
			latency = bits;
			redirect = 1'b0;
			if (next_redirect < redirects && accepted == golden['h50 + 3 * next_redirect]) begin
				base = 'h50 + 3 * next_redirect;
				// mode 1 waits until the next word is held so nothing is in flight
				if (golden[base + 2] == 0 || out_valid) begin
					redirect = 1'b1;
					redirect_info.target = golden[base + 1];
					next_redirect++;
				end
				if (golden[base + 2] != 0)
					out_ready = 1'b0;
			end
		end
		out_ready = 1'b0;
		redirect = 1'b0;
		report_test(1);

		compare(2, "bus request count", golden[3], final_reqs);
		report_test(2);

		test_errors[3] = dut_i.chk_i.failures;
		report_test(3);

		total = test_errors[0] + test_errors[1] + test_errors[2] + test_errors[3];
		$display("4 tests, %0d failed, %0d errors", failed_tests, total);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/mem_bus_pkg.sv
src/fetch_pkg.sv
src/pc_sequencer.sv
src/icache_array.sv
src/fetch_bus_master.sv
src/decode_handoff.sv
src/fetch_top.sv
sim/fetch_mem_model.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/mem_bus_pkg.sv
      - src/fetch_pkg.sv
      - src/pc_sequencer.sv
      - src/icache_array.sv
      - src/fetch_bus_master.sv
      - src/decode_handoff.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/fetch_mem_model.sv
      - sim/fetch_chk.sv
      - sim/fetch_tb.sv

//--- sim/fetch_golden.hex
// words 0-3: memory pairs, redirects, expected outputs, expected bus requests
// memory: addr data | redirect: accepted count, target, mode (1 = wait for held word) | expected: pc insn
@00
0000000d 00000004 00000012 00000009
@10
80000000 00000093 80000004 00a00113
80000008 00108093 8000000c fff10113
80000010 002081b3 80000014 fe0118e3
80000018 00302023 8000001c 000010b7
80000020 00400293 80000024 0000006f
00001000 00128293 00001004 ffdff06f
00001008 00000013
@50
00000006 80000008 00000001
0000000c 00001000 00000000
0000000e 00001000 00000001
00000010 80000020 00000000
@80
80000000 00000093 80000004 00a00113
80000008 00108093 8000000c fff10113
80000010 002081b3 80000014 fe0118e3
80000008 00108093 8000000c fff10113
80000010 002081b3 80000014 fe0118e3
80000018 00302023 8000001c 000010b7
00001000 00128293 00001004 ffdff06f
00001000 00128293 00001004 ffdff06f
80000020 00400293 80000024 0000006f
